// ==== Makefile ====
TB_TOP := mem_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f mem_stage_top.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f mem_stage_top.f --top-module $(TB_TOP) -o simv
	@out="$$(./obj_dir/simv 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

// ==== bench/mem_stage_asserts.sv ====
`timescale 1ns/100ps

module mem_stage_asserts #(
    parameter bit ON_LSU = 1'b0
) (
    input logic         clk,
    input logic         rst,
    input logic         valid,
    input logic         ready,
    input logic [1:0]   req,
    input logic [31:0]  addr,
    input logic [1:0]   size,
    input logic [63:0]  wdata,
    input logic         done,
    input logic         update
);

    if (ON_LSU) begin : g_lsu
        // A stalled request must not change until it is taken.
        a_req_stable: assert property (@(posedge clk) disable iff (rst)
            valid && !ready |=> valid && $stable(req) && $stable(addr) && $stable(size) &&
                                $stable(wdata))
            else $error("bus request changed while stalled");

        a_done_after_hs: assert property (@(posedge clk) disable iff (rst)
            valid && ready |=> done)
            else $error("done missing after handshake");
        a_done_only_after_hs: assert property (@(posedge clk) disable iff (rst)
            done |-> $past(valid && ready))
            else $error("done without a handshake");
    end else begin : g_clint
        a_update_single: assert property (@(posedge clk) disable iff (rst)
            update |=> !update)
            else $error("update pulse longer than one cycle");
    end

endmodule

bind lsu_ctrl mem_stage_asserts #(.ON_LSU(1'b1)) lsu_chk (
    .clk (clk), .rst (rst), .valid (bus.valid), .ready (bus.ready), .req (bus.req),
    .addr (bus.addr), .size (bus.size), .wdata (bus.wdata), .done (done_o), .update (1'b0)
);

bind mem_clint mem_stage_asserts #(.ON_LSU(1'b0)) clint_chk (
    .clk (clk), .rst (rst), .valid (bus.valid), .ready (bus.ready), .req (bus.req),
    .addr (bus.addr), .size (bus.size), .wdata (bus.wdata), .done (1'b0), .update (update_o)
);

// ==== bench/mem_stage_tb.sv ====
`timescale 1ns/100ps

module mem_stage_tb;

    localparam int N_INIT     = clint_map_pkg::RAM_WORDS;   // One store per RAM word.
    localparam int N_ROUND    = 40;
    localparam int N_EXT      = 8;                      // Loads per load opcode.
    localparam int N_MTIME    = 4;
    localparam int GAP_MAX    = 30;
    localparam int N_CMDS     = N_INIT + 2 * N_ROUND + 7 * N_EXT + 2 * N_MTIME + 3 + 3;
    localparam int WD_CYCLES  = 200 + 5 * N_CMDS + N_MTIME * GAP_MAX;

    logic                               clk = 1'b0;
    logic                               rst;
    logic                               cmd_valid_i;
    cpu_bus_pkg::op_t                   cmd_op_i;
    logic [cpu_bus_pkg::ADDR_W-1:0]     cmd_addr_i;
    logic [cpu_bus_pkg::DATA_W-1:0]     cmd_wdata_i;
    logic                               cmd_ready_o;
    logic                               done_o;
    logic [cpu_bus_pkg::DATA_W-1:0]     rdata_o;
    logic                               err_o;
    logic                               timer_irq_o;
    logic                               clint_update_o;

    logic [cpu_bus_pkg::DATA_W-1:0]     ram_model [int];    // Keyed by doubleword index.
    longint                             cycle_cnt = 0;
    longint                             last_done;

    mem_stage_top dut0 (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [cpu_bus_pkg::DATA_W-1:0] ref_load(
        input cpu_bus_pkg::op_t op, input logic [31:0] addr);
        logic [63:0] lane;
        lane = ram_model[int'(addr[8:3])] >> (8 * addr[2:0]);
        case (op)
            cpu_bus_pkg::OP_LB:  return {{56{lane[7]}}, lane[7:0]};
            cpu_bus_pkg::OP_LBU: return {56'd0, lane[7:0]};
            cpu_bus_pkg::OP_LH:  return {{48{lane[15]}}, lane[15:0]};
            cpu_bus_pkg::OP_LHU: return {48'd0, lane[15:0]};
            cpu_bus_pkg::OP_LW:  return {{32{lane[31]}}, lane[31:0]};
            cpu_bus_pkg::OP_LWU: return {32'd0, lane[31:0]};
            default:             return lane;
        endcase
    endfunction

    // Merge the low bytes of a store into the model word.
    function automatic void ref_store(input int nbytes, input logic [31:0] addr,
                                      input logic [63:0] wdata);
        int word;
        word = int'(addr[8:3]);
        for (int b = 0; b < nbytes; b++) begin
            ram_model[word][(addr[2:0] + b) * 8 +: 8] = wdata[b * 8 +: 8];
        end
    endfunction

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_data(input string name, input logic [cpu_bus_pkg::DATA_W-1:0] exp,
                              input logic [cpu_bus_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            stop_with_fail($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_fail($sformatf("Fail %s expected %b actual %b", name, exp, act));
        end
    endtask

    // Called one step after a rising edge; returns at the sample where done_o is high.
    task automatic run_cmd(input cpu_bus_pkg::op_t op, input logic [31:0] addr,
                           input logic [63:0] wdata, input logic timer_wr,
                           output logic [63:0] rdata, output logic err);
        if (!cmd_ready_o) begin
            stop_with_fail("DUT did not offer cmd_ready for a new command");
        end
        cmd_valid_i = 1'b1;
        cmd_op_i    = op;
        cmd_addr_i  = addr;
        cmd_wdata_i = wdata;
        @(posedge clk);
        #1;
        cmd_valid_i = 1'b0;
        while (!done_o) begin
            check_err("update_idle", 1'b0, clint_update_o);
            check_err("busy_ready", 1'b0, cmd_ready_o);
            @(posedge clk);
            #1;
        end
        check_err("update_pulse", timer_wr, clint_update_o);
        rdata     = rdata_o;
        err       = err_o;
        last_done = cycle_cnt;
    endtask

    function automatic cpu_bus_pkg::op_t store_op(input int size);
        case (size)
            0:       return cpu_bus_pkg::OP_SB;
            1:       return cpu_bus_pkg::OP_SH;
            2:       return cpu_bus_pkg::OP_SW;
            default: return cpu_bus_pkg::OP_SD;
        endcase
    endfunction

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        cpu_bus_pkg::op_t   lds [7];
        logic [63:0]        rd;
        logic [63:0]        wv;
        logic [63:0]        mt_val;
        logic [31:0]        addr;
        logic               er;
        longint             mt_done;
        int                 size;
        int                 gap;

        lds = '{cpu_bus_pkg::OP_LB, cpu_bus_pkg::OP_LBU, cpu_bus_pkg::OP_LH,
                cpu_bus_pkg::OP_LHU, cpu_bus_pkg::OP_LW, cpu_bus_pkg::OP_LWU, cpu_bus_pkg::OP_LD};
        void'($urandom(32'h23bb));
        rst         = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_op_i    = cpu_bus_pkg::OP_LD;
        cmd_addr_i  = '0;
        cmd_wdata_i = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_err("irq_after_reset", 1'b1, timer_irq_o);

        for (int w = 0; w < N_INIT; w++) begin
            wv   = {$urandom, $urandom};
            addr = clint_map_pkg::RAM_BASE + w * 8;
            ref_store(8, addr, wv);
            run_cmd(cpu_bus_pkg::OP_SD, addr, wv, 1'b0, rd, er);
            check_err("ram_init_err", 1'b0, er);
        end

        // Stores of every width, each followed by a doubleword read-back.
        for (int i = 0; i < N_ROUND; i++) begin
            size = $urandom_range(3);
            wv   = {$urandom, $urandom};
            addr = clint_map_pkg::RAM_BASE + ($urandom_range(511) & ~((1 << size) - 1));
            ref_store(1 << size, addr, wv);
            run_cmd(store_op(size), addr, wv, 1'b0, rd, er);
            check_err("round_store_err", 1'b0, er);
            run_cmd(cpu_bus_pkg::OP_LD, addr & ~32'h7, '0, 1'b0, rd, er);
            check_data("round_trip", ref_load(cpu_bus_pkg::OP_LD, addr & ~32'h7), rd);
        end

        foreach (lds[k]) begin
            for (int i = 0; i < N_EXT; i++) begin
                size = (k == 6) ? 3 : k / 2;
                addr = clint_map_pkg::RAM_BASE + ($urandom_range(511) & ~((1 << size) - 1));
                run_cmd(lds[k], addr, '0, 1'b0, rd, er);
                check_data($sformatf("load_ext_%s", lds[k].name()), ref_load(lds[k], addr), rd);
                check_err("load_ext_err", 1'b0, er);
            end
        end

        // mtime holds the written value in the write's done cycle and counts up after.
        for (int i = 0; i < N_MTIME; i++) begin
            mt_val = {16'd0, 16'($urandom_range(16'hFFFF)), $urandom};
            run_cmd(cpu_bus_pkg::OP_SD, clint_map_pkg::MTIME_ADDR, mt_val, 1'b1, rd, er);
            mt_done = last_done;
            gap = $urandom_range(GAP_MAX);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            run_cmd(cpu_bus_pkg::OP_LD, clint_map_pkg::MTIME_ADDR, '0, 1'b0, rd, er);
            check_data("mtime_count", mt_val + (last_done - mt_done) - 1, rd);
        end

        run_cmd(cpu_bus_pkg::OP_SD, clint_map_pkg::MTIMECMP_ADDR, 64'hFFFF_FFFF_FFFF_0000,
                1'b1, rd, er);
        check_err("irq_low", 1'b0, timer_irq_o);
        // Predict mtime at the handshake edge, two edges after this drive point.
        wv = mt_val + (cycle_cnt + 2 - mt_done);
        run_cmd(cpu_bus_pkg::OP_SD, clint_map_pkg::MTIMECMP_ADDR, wv, 1'b1, rd, er);
        check_err("irq_high", 1'b1, timer_irq_o);
        run_cmd(cpu_bus_pkg::OP_LD, clint_map_pkg::MTIMECMP_ADDR, '0, 1'b0, rd, er);
        check_data("mtimecmp_read", wv, rd);

        run_cmd(cpu_bus_pkg::OP_LD, 32'h1000_0000, '0, 1'b0, rd, er);
        check_err("unmapped_load_err", 1'b1, er);
        check_data("unmapped_load_data", '0, rd);
        run_cmd(cpu_bus_pkg::OP_SD, clint_map_pkg::RAM_BASE + 32'h200, 64'hDEAD_BEEF_0BAD_F00D,
                1'b0, rd, er);
        check_err("unmapped_store_err", 1'b1, er);
        run_cmd(cpu_bus_pkg::OP_LD, clint_map_pkg::RAM_BASE, '0, 1'b0, rd, er);
        check_data("ram_unchanged", ref_load(cpu_bus_pkg::OP_LD, clint_map_pkg::RAM_BASE), rd);
        check_err("ram_unchanged_err", 1'b0, er);

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== mem_stage_top.f ====
src/cpu_bus_pkg.sv
src/clint_map_pkg.sv
src/mem_bus_if.sv
src/lsu_ctrl.sv
src/mem_router.sv
src/mem_clint.sv
src/data_ram.sv
src/mem_stage_top.sv
bench/mem_stage_asserts.sv
bench/mem_stage_tb.sv

// ==== src/clint_map_pkg.sv ====
package clint_map_pkg;

    // Core-local timer registers, at the usual CLINT offsets.
    localparam logic [31:0] MTIMECMP_ADDR = 32'h0200_4000;
    localparam logic [31:0] MTIME_ADDR    = 32'h0200_BFF8;

    // Data RAM window starts at the RAM base and spans RAM_WORDS doublewords.
    localparam logic [31:0] RAM_BASE      = 32'h8000_0000;
    localparam int unsigned RAM_WORDS     = 64;

endpackage

// ==== src/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

    localparam int DATA_W = 64;                 // Register and bus data width.
    localparam int ADDR_W = 32;                 // Byte address width.
    localparam int STRB_W = DATA_W / 8;         // One enable per data byte.

    typedef enum logic [1:0] {
        REQ_NONE  = 2'd0,
        REQ_READ  = 2'd1,
        REQ_WRITE = 2'd2
    } req_t;

    // Access size follows the RISC-V funct3 width encoding.
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } size_t;

    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00,
        RESP_ERR  = 2'b10                       // Same code as an AXI slave error.
    } resp_t;

    typedef enum logic [3:0] {
        OP_LB  = 4'd0,
        OP_LBU = 4'd1,
        OP_LH  = 4'd2,
        OP_LHU = 4'd3,
        OP_LW  = 4'd4,
        OP_LWU = 4'd5,
        OP_LD  = 4'd6,
        OP_SB  = 4'd7,
        OP_SH  = 4'd8,
        OP_SW  = 4'd9,
        OP_SD  = 4'd10
    } op_t;

endpackage

// ==== src/data_ram.sv ====
`timescale 1ns/100ps

module data_ram (
    input  logic        clk,
    input  logic        rst,
    mem_bus_if.slave    bus
);

    localparam int IDX_W = $clog2(clint_map_pkg::RAM_WORDS);

    logic [cpu_bus_pkg::DATA_W-1:0]     mem [clint_map_pkg::RAM_WORDS];
    logic [IDX_W-1:0]                   idx;        // Doubleword index.
    logic [cpu_bus_pkg::STRB_W-1:0]     be;
    logic [cpu_bus_pkg::DATA_W-1:0]     rdata_q;
    logic                               ready_q;
    logic                               wr;

    assign idx = bus.addr[IDX_W+2:3];
    assign wr  = bus.valid & ready_q & (bus.req == cpu_bus_pkg::REQ_WRITE);

    // Byte enables from the access width, moved up by the byte offset.
    always_comb begin
        case (bus.size)
            cpu_bus_pkg::SIZE_B: be = 8'h01;
            cpu_bus_pkg::SIZE_H: be = 8'h03;
            cpu_bus_pkg::SIZE_W: be = 8'h0F;
            default:             be = 8'hFF;
        endcase
        be = be << bus.addr[2:0];
    end

    // Ready rises one cycle after valid and falls right after the handshake.
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= bus.valid & ~ready_q;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.valid && !ready_q) begin
            rdata_q <= mem[idx];                        // Read in the wait cycle.
        end
        if (wr) begin
            for (int b = 0; b < cpu_bus_pkg::STRB_W; b++) begin
                if (be[b]) begin
                    mem[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
                end
            end
        end
    end

    assign bus.ready = ready_q;
    assign bus.rdata = rdata_q;
    assign bus.resp  = cpu_bus_pkg::RESP_OKAY;

endmodule

// ==== src/lsu_ctrl.sv ====
`timescale 1ns/100ps

module lsu_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmd_valid_i,
    input  cpu_bus_pkg::op_t                cmd_op_i,
    input  logic [cpu_bus_pkg::ADDR_W-1:0]  cmd_addr_i,
    input  logic [cpu_bus_pkg::DATA_W-1:0]  cmd_wdata_i,
    output logic                            cmd_ready_o,
    output logic                            done_o,
    output logic [cpu_bus_pkg::DATA_W-1:0]  rdata_o,
    output logic                            err_o,
    mem_bus_if.master                       bus
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t                             state;
    cpu_bus_pkg::op_t                   op_q;       // Opcode of the command in flight.
    logic [cpu_bus_pkg::ADDR_W-1:0]     addr_q;
    logic [cpu_bus_pkg::DATA_W-1:0]     wdata_q;    // Store data shifted to its lane.
    cpu_bus_pkg::req_t                  req_kind;
    cpu_bus_pkg::size_t                 req_size;
    logic [cpu_bus_pkg::DATA_W-1:0]     lane;       // Load data moved down to bit 0.
    logic [cpu_bus_pkg::DATA_W-1:0]     ld_ext;
    logic                               accept;
    logic                               hs;

    assign cmd_ready_o = (state == ST_IDLE);
    assign accept      = cmd_valid_i & cmd_ready_o;
    assign hs          = bus.valid & bus.ready;

    // Decode the opcode into bus request kind and access width.
    always_comb begin
        req_kind = cpu_bus_pkg::REQ_READ;
        req_size = cpu_bus_pkg::SIZE_D;
        case (op_q)
            cpu_bus_pkg::OP_LB, cpu_bus_pkg::OP_LBU: req_size = cpu_bus_pkg::SIZE_B;
            cpu_bus_pkg::OP_LH, cpu_bus_pkg::OP_LHU: req_size = cpu_bus_pkg::SIZE_H;
            cpu_bus_pkg::OP_LW, cpu_bus_pkg::OP_LWU: req_size = cpu_bus_pkg::SIZE_W;
            cpu_bus_pkg::OP_SB: begin
                req_kind = cpu_bus_pkg::REQ_WRITE;
                req_size = cpu_bus_pkg::SIZE_B;
            end
            cpu_bus_pkg::OP_SH: begin
                req_kind = cpu_bus_pkg::REQ_WRITE;
                req_size = cpu_bus_pkg::SIZE_H;
            end
            cpu_bus_pkg::OP_SW: begin
                req_kind = cpu_bus_pkg::REQ_WRITE;
                req_size = cpu_bus_pkg::SIZE_W;
            end
            cpu_bus_pkg::OP_SD: req_kind = cpu_bus_pkg::REQ_WRITE;
            default:            req_size = cpu_bus_pkg::SIZE_D;
        endcase
    end

    assign bus.valid = (state == ST_BUSY);
    assign bus.req   = req_kind;
    assign bus.addr  = addr_q;
    assign bus.size  = req_size;
    assign bus.wdata = wdata_q;

    // Bring the addressed bytes down to bit 0, then extend per opcode.
    assign lane = bus.rdata >> {addr_q[2:0], 3'b000};

    always_comb begin
        case (op_q)
            cpu_bus_pkg::OP_LB:  ld_ext = {{(cpu_bus_pkg::DATA_W-8){lane[7]}}, lane[7:0]};
            cpu_bus_pkg::OP_LBU: ld_ext = {{(cpu_bus_pkg::DATA_W-8){1'b0}}, lane[7:0]};
            cpu_bus_pkg::OP_LH:  ld_ext = {{(cpu_bus_pkg::DATA_W-16){lane[15]}}, lane[15:0]};
            cpu_bus_pkg::OP_LHU: ld_ext = {{(cpu_bus_pkg::DATA_W-16){1'b0}}, lane[15:0]};
            cpu_bus_pkg::OP_LW:  ld_ext = {{(cpu_bus_pkg::DATA_W-32){lane[31]}}, lane[31:0]};
            cpu_bus_pkg::OP_LWU: ld_ext = {{(cpu_bus_pkg::DATA_W-32){1'b0}}, lane[31:0]};
            cpu_bus_pkg::OP_LD:  ld_ext = lane;
            default:             ld_ext = '0;                   // Stores return no data.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            done_o <= 1'b0;
            err_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;                                     // Done is a single pulse.
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (hs) begin
                        state  <= ST_IDLE;
                        done_o <= 1'b1;
                        err_o  <= (bus.resp == cpu_bus_pkg::RESP_ERR);
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command and result payload.
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= cmd_op_i;
            addr_q  <= cmd_addr_i;
            wdata_q <= cmd_wdata_i << {cmd_addr_i[2:0], 3'b000};    // Place in byte lane.
        end
        if (hs) begin
            rdata_o <= ld_ext;
        end
    end

endmodule

// ==== src/mem_bus_if.sv ====
`timescale 1ns/100ps

interface mem_bus_if;

    logic                               valid;  // Request present.
    cpu_bus_pkg::req_t                  req;    // Read or write.
    logic [cpu_bus_pkg::ADDR_W-1:0]     addr;   // Byte address.
    cpu_bus_pkg::size_t                 size;   // Access width.
    logic [cpu_bus_pkg::DATA_W-1:0]     wdata;  // Store data, already in its byte lane.

    logic                               ready;  // Target takes the request this cycle.
    logic [cpu_bus_pkg::DATA_W-1:0]     rdata;  // Load data, valid with ready.
    cpu_bus_pkg::resp_t                 resp;   // Status, valid with ready.

    modport master (
        output valid, req, addr, size, wdata,
        input  ready, rdata, resp
    );

    modport slave (
        input  valid, req, addr, size, wdata,
        output ready, rdata, resp
    );

endinterface

// ==== src/mem_clint.sv ====
`timescale 1ns/100ps

module mem_clint (
    input  logic        clk,
    input  logic        rst,
    mem_bus_if.slave    bus,
    output logic        mtip_o,
    output logic        update_o
);

    logic [cpu_bus_pkg::DATA_W-1:0]     mtime_q;
    logic [cpu_bus_pkg::DATA_W-1:0]     mtimecmp_q;
    logic                               sel_mtime;
    logic                               sel_mtimecmp;
    logic                               wr;
    logic                               rd;

    assign sel_mtime    = (bus.addr == clint_map_pkg::MTIME_ADDR);
    assign sel_mtimecmp = (bus.addr == clint_map_pkg::MTIMECMP_ADDR);
    assign wr           = bus.valid & bus.ready & (bus.req == cpu_bus_pkg::REQ_WRITE);
    assign rd           = bus.valid & (bus.req == cpu_bus_pkg::REQ_READ);

    // The timer counts every cycle unless software loads it.
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q <= '0;
        end else if (wr && sel_mtime) begin
            mtime_q <= bus.wdata;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_q <= '0;
        end else if (wr && sel_mtimecmp) begin
            mtimecmp_q <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            update_o <= 1'b0;
        end else begin
            update_o <= wr;                             // One cycle after any timer write.
        end
    end

    assign bus.ready = 1'b1;                            // Registers never stall.
    assign bus.resp  = cpu_bus_pkg::RESP_OKAY;
    assign bus.rdata = (rd && sel_mtime)    ? mtime_q    :
                       (rd && sel_mtimecmp) ? mtimecmp_q : '0;

    assign mtip_o = (mtime_q >= mtimecmp_q);            // Level interrupt, high from reset.

endmodule

// ==== src/mem_router.sv ====
`timescale 1ns/100ps

module mem_router (
    mem_bus_if.slave    bus_m,
    mem_bus_if.master   bus_clint,
    mem_bus_if.master   bus_ram
);

    logic                               hit_clint;
    logic                               hit_ram;
    logic [cpu_bus_pkg::ADDR_W-1:0]     ram_off;    // Byte offset into the RAM window.

    assign hit_clint = (bus_m.addr == clint_map_pkg::MTIME_ADDR) ||
                       (bus_m.addr == clint_map_pkg::MTIMECMP_ADDR);

    // Addresses below the base wrap to a large offset and miss.
    assign ram_off = bus_m.addr - clint_map_pkg::RAM_BASE;
    assign hit_ram = ram_off < (clint_map_pkg::RAM_WORDS * 8);

    // Request fields go to both targets; only the selected one sees valid.
    assign bus_clint.valid = bus_m.valid & hit_clint;
    assign bus_clint.req   = bus_m.req;
    assign bus_clint.addr  = bus_m.addr;
    assign bus_clint.size  = bus_m.size;
    assign bus_clint.wdata = bus_m.wdata;

    assign bus_ram.valid   = bus_m.valid & hit_ram & ~hit_clint;
    assign bus_ram.req     = bus_m.req;
    assign bus_ram.addr    = bus_m.addr;
    assign bus_ram.size    = bus_m.size;
    assign bus_ram.wdata   = bus_m.wdata;

    always_comb begin
        if (hit_clint) begin
            bus_m.ready = bus_clint.ready;
            bus_m.rdata = bus_clint.rdata;
            bus_m.resp  = bus_clint.resp;
        end else if (hit_ram) begin
            bus_m.ready = bus_ram.ready;
            bus_m.rdata = bus_ram.rdata;
            bus_m.resp  = bus_ram.resp;
        end else begin
            bus_m.ready = 1'b1;                         // Unmapped, answer at once.
            bus_m.rdata = '0;
            bus_m.resp  = cpu_bus_pkg::RESP_ERR;
        end
    end

endmodule

// ==== src/mem_stage_top.sv ====
`timescale 1ns/100ps

module mem_stage_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmd_valid_i,
    input  cpu_bus_pkg::op_t                cmd_op_i,
    input  logic [cpu_bus_pkg::ADDR_W-1:0]  cmd_addr_i,
    input  logic [cpu_bus_pkg::DATA_W-1:0]  cmd_wdata_i,
    output logic                            cmd_ready_o,
    output logic                            done_o,
    output logic [cpu_bus_pkg::DATA_W-1:0]  rdata_o,
    output logic                            err_o,
    output logic                            timer_irq_o,
    output logic                            clint_update_o
);

    mem_bus_if bus_lsu ();                              // Load/store unit to router.
    mem_bus_if bus_clint ();                            // Router to timer.
    mem_bus_if bus_ram ();                              // Router to data RAM.

    lsu_ctrl lsu0 (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_i (cmd_valid_i),
        .cmd_op_i    (cmd_op_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_wdata_i (cmd_wdata_i),
        .cmd_ready_o (cmd_ready_o),
        .done_o      (done_o),
        .rdata_o     (rdata_o),
        .err_o       (err_o),
        .bus         (bus_lsu.master)
    );

    mem_router router0 (
        .bus_m     (bus_lsu.slave),
        .bus_clint (bus_clint.master),
        .bus_ram   (bus_ram.master)
    );

    mem_clint clint0 (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus_clint.slave),
        .mtip_o   (timer_irq_o),
        .update_o (clint_update_o)
    );

    data_ram ram0 (
        .clk (clk),
        .rst (rst),
        .bus (bus_ram.slave)
    );

endmodule
